//--- design/chassis_power_macros.svh
`ifndef CHASSIS_POWER_MACROS_SVH
`define CHASSIS_POWER_MACROS_SVH

// Width of the sequencer wait counter
`define TIMER_WIDTH 16

// Button filter
`define DEBOUNCE_WIDTH  5   // Holds 0 .. DEBOUNCE_CYCLES-1
`define DEBOUNCE_CYCLES 16  // Cycles a new level must hold before it counts

// Sequencer waits, in gclk40 cycles
`define PG_TIMEOUT_CYCLES      200  // Supply on to power-good, worst case
`define POWER_DOWN_WAIT_CYCLES 100  // Press to supply off

// LED blink counter and the bits that set the two blink rates
`define BLINK_WIDTH    8
`define SLOW_BLINK_BIT 7
`define FAST_BLINK_BIT 5

`endif

//--- design/chassis_power_pkg.sv
`default_nettype none

package chassis_power_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Power sequencer states
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    OFF       = 2'b00,  // Supply off, waiting for a press
    WAIT_PG   = 2'b01,  // Supply requested, waiting for power-good
    ON        = 2'b10,  // Board powered
    DOWN_WAIT = 2'b11   // Orderly shutdown in progress
  } power_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Why the board has no power
  ////////////////////////////////////////////////////////////////////////////
  // The two abnormal causes sit at 01 and 10
  typedef enum logic [1:0] {
    CAUSE_NONE       = 2'b00,
    CAUSE_POWER_LOST = 2'b01,
    CAUSE_PG_TIMEOUT = 2'b10,
    CAUSE_BUTTON     = 2'b11
  } no_power_cause_t;

endpackage

`default_nettype wire

//--- design/seq_timer_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "chassis_power_macros.svh"

// Link between the power sequencer and its wait timer
interface seq_timer_if;

  logic                    start;       // One-cycle pulse, (re)loads the counter
  logic [`TIMER_WIDTH-1:0] load_value;  // Wait length in cycles
  logic                    busy;        // A wait is running
  logic                    done;        // One-cycle pulse when the wait ends

  modport sequencer (output start, output load_value, input busy, input done);
  modport timer     (input start, input load_value, output busy, output done);

endinterface

`default_nettype wire

//--- design/switch_debouncer.sv
`timescale 1ns/1ps
`default_nettype none

`include "chassis_power_macros.svh"

module switch_debouncer (
  input  wire logic gclk40,
  input  wire logic hard_reset,
  input  wire logic switch_n_i,  // Front-panel button, low when pressed
  output logic      press_o      // One pulse per accepted press
);

  logic                       sync_meta_q;
  logic                       sync_q;
  logic                       level_q;  // Debounced level, high means pressed
  logic [`DEBOUNCE_WIDTH-1:0] stable_cnt_q;
  logic                       pressed;
  logic                       settled;

  // Two-flop synchronizer, idles at released
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      sync_meta_q <= 1'b1;
      sync_q      <= 1'b1;
    end else begin
      sync_meta_q <= switch_n_i;
      sync_q      <= sync_meta_q;
    end
  end

  assign pressed = ~sync_q;
  // Last cycle of a run that differs from the debounced level
  assign settled = (stable_cnt_q == `DEBOUNCE_WIDTH'(`DEBOUNCE_CYCLES - 1));

  // Count how long the input has differed from the debounced level.
  // Any return to the old level restarts the count
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      stable_cnt_q <= '0;
      level_q      <= 1'b0;
      press_o      <= 1'b0;
    end else begin
      press_o <= 1'b0;
      if (pressed == level_q) begin
        stable_cnt_q <= '0;
      end else if (settled) begin
        stable_cnt_q <= '0;
        level_q      <= pressed;
        press_o      <= pressed;  // Rising edge of the debounced level only
      end else begin
        stable_cnt_q <= stable_cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/sequence_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "chassis_power_macros.svh"

module sequence_timer (
  input  wire logic  gclk40,
  input  wire logic  hard_reset,
  seq_timer_if.timer tmr
);

  logic [`TIMER_WIDTH-1:0] count_q;
  logic                    busy_q;

  ////////////////////////////////////////////////////////////////////////////
  // Down-counter
  ////////////////////////////////////////////////////////////////////////////
  // A start always wins, so a new wait throws away the one in progress
  always_ff @(posedge gclk40) begin
    if (tmr.start) begin
      count_q <= tmr.load_value;
    end else if (busy_q) begin
      count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      busy_q <= 1'b0;
    end else if (tmr.start) begin
      busy_q <= 1'b1;
    end else if (tmr.done) begin
      busy_q <= 1'b0;  // Wait is over
    end
  end

  // The counter holds 1 in the cycle that is load_value cycles after start.
  // A start in that same cycle discards the old count and its done pulse
  assign tmr.busy = busy_q;
  assign tmr.done = busy_q && !tmr.start && (count_q == `TIMER_WIDTH'(1));

endmodule

`default_nettype wire

//--- design/power_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "chassis_power_macros.svh"

module power_sequencer import chassis_power_pkg::*; (
  input  wire logic      gclk40,
  input  wire logic      hard_reset,
  input  wire logic      press_i,       // Debounced button press
  input  wire logic      atx_pwr_ok_i,  // ATX power-good, asynchronous
  seq_timer_if.sequencer tmr,
  output power_state_t   state_o,
  output no_power_cause_t cause_o,
  output logic           ps_on_n_o,     // ATX supply enable, active low
  output logic           power_ok_o,
  output logic           controller_reset_o
);

  logic                    pg_meta_q;
  logic                    pg_q;
  power_state_t            state_q;
  power_state_t            state_d;
  no_power_cause_t         cause_q;
  no_power_cause_t         cause_d;
  logic                    start_q;
  logic [`TIMER_WIDTH-1:0] load_q;
  logic                    enter_wait_pg;
  logic                    enter_down_wait;

  ////////////////////////////////////////////////////////////////////////////
  // Power-good synchronizer
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      pg_meta_q <= 1'b0;
      pg_q      <= 1'b0;
    end else begin
      pg_meta_q <= atx_pwr_ok_i;
      pg_q      <= pg_meta_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next-state logic
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    cause_d = cause_q;
    case (state_q)
      OFF: begin
        if (press_i) begin
          state_d = WAIT_PG;  // Old cause stays until a new one arrives
        end
      end
      WAIT_PG: begin
        if (pg_q) begin
          state_d = ON;
        end else if (tmr.done) begin
          state_d = OFF;
          cause_d = CAUSE_PG_TIMEOUT;
        end
      end
      ON: begin
        // Supply dropout takes priority over a press in the same cycle
        if (!pg_q) begin
          state_d = OFF;
          cause_d = CAUSE_POWER_LOST;
        end else if (press_i) begin
          state_d = DOWN_WAIT;
        end
      end
      DOWN_WAIT: begin
        // Power-good is ignored here because the supply is on its way down anyway
        if (tmr.done) begin
          state_d = OFF;
          cause_d = CAUSE_BUTTON;
        end
      end
      default: begin
        state_d = OFF;
      end
    endcase
  end

  assign enter_wait_pg   = (state_d == WAIT_PG) && (state_q != WAIT_PG);
  assign enter_down_wait = (state_d == DOWN_WAIT) && (state_q != DOWN_WAIT);

  ////////////////////////////////////////////////////////////////////////////
  // State, cause and registered outputs
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      state_q            <= OFF;
      cause_q            <= CAUSE_NONE;
      start_q            <= 1'b0;
      ps_on_n_o          <= 1'b1;
      power_ok_o         <= 1'b0;
      controller_reset_o <= 1'b1;
    end else begin
      state_q            <= state_d;
      cause_q            <= cause_d;
      start_q            <= enter_wait_pg || enter_down_wait;
      ps_on_n_o          <= (state_d == OFF);
      power_ok_o         <= (state_d == ON);
      controller_reset_o <= (state_d != ON);  // Controller held until power is good
    end
  end

  // The timer samples the wait length only together with start
  always_ff @(posedge gclk40) begin
    if (enter_wait_pg) begin
      load_q <= `TIMER_WIDTH'(`PG_TIMEOUT_CYCLES);
    end else if (enter_down_wait) begin
      load_q <= `TIMER_WIDTH'(`POWER_DOWN_WAIT_CYCLES);
    end
  end

  assign tmr.start      = start_q;
  assign tmr.load_value = load_q;

  assign state_o = state_q;
  assign cause_o = cause_q;

endmodule

`default_nettype wire

//--- design/status_leds.sv
`timescale 1ns/1ps
`default_nettype none

`include "chassis_power_macros.svh"

module status_leds import chassis_power_pkg::*; (
  input  wire logic            gclk40,
  input  wire logic            hard_reset,
  input  wire power_state_t    state_i,
  input  wire no_power_cause_t cause_i,
  output logic [1:0]           led_n_o   // Bit 0 power, bit 1 action, active low
);

  logic [`BLINK_WIDTH-1:0] blink_q;
  logic                    bad_power_down;
  logic                    power_led;
  logic                    action_led;

  // Free-running blink counter
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      blink_q <= '0;
    end else begin
      blink_q <= blink_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // LED mapping
  ////////////////////////////////////////////////////////////////////////////
  assign bad_power_down = (cause_i == CAUSE_POWER_LOST) ||
                          (cause_i == CAUSE_PG_TIMEOUT);

  always_comb begin
    if (state_i == ON) begin
      power_led  = 1'b1;
      action_led = 1'b0;
    end else begin
      power_led  = blink_q[`SLOW_BLINK_BIT];  // Slow blink while unpowered
      // Fast blink flags an abnormal power-down
      action_led = bad_power_down ? blink_q[`FAST_BLINK_BIT] : 1'b0;
    end
  end

  // Both LEDs light during reset as a lamp test
  assign led_n_o = hard_reset ? ~{action_led, power_led} : 2'b00;

endmodule

`default_nettype wire

//--- design/chassis_power_top.sv
`timescale 1ns/1ps
`default_nettype none

module chassis_power_top import chassis_power_pkg::*; (
  input  wire logic       gclk40,
  input  wire logic       hard_reset,        // Synchronous, active low
  input  wire logic       chs_powerdown_n_i, // Front-panel power button
  input  wire logic       atx_pwr_ok_i,
  output logic            ps_on_n_o,
  output logic            power_ok_o,
  output logic            controller_reset_o,
  output no_power_cause_t no_power_cause_o,
  output logic [1:0]      chs_led_n_o        // Bit 0 power, bit 1 action
);

  logic         press;
  power_state_t power_state;

  seq_timer_if seq_tmr ();

  ////////////////////////////////////////////////////////////////////////////
  // Button filter
  ////////////////////////////////////////////////////////////////////////////
  switch_debouncer switch_debouncer_inst (
    .gclk40     (gclk40),
    .hard_reset (hard_reset),
    .switch_n_i (chs_powerdown_n_i),
    .press_o    (press)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer and its wait timer
  ////////////////////////////////////////////////////////////////////////////
  power_sequencer power_sequencer_inst (
    .gclk40             (gclk40),
    .hard_reset         (hard_reset),
    .press_i            (press),
    .atx_pwr_ok_i       (atx_pwr_ok_i),
    .tmr                (seq_tmr.sequencer),
    .state_o            (power_state),
    .cause_o            (no_power_cause_o),
    .ps_on_n_o          (ps_on_n_o),
    .power_ok_o         (power_ok_o),
    .controller_reset_o (controller_reset_o)
  );

  sequence_timer sequence_timer_inst (
    .gclk40     (gclk40),
    .hard_reset (hard_reset),
    .tmr        (seq_tmr.timer)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Chassis LEDs
  ////////////////////////////////////////////////////////////////////////////
  status_leds status_leds_inst (
    .gclk40     (gclk40),
    .hard_reset (hard_reset),
    .state_i    (power_state),
    .cause_i    (no_power_cause_o),
    .led_n_o    (chs_led_n_o)
  );

endmodule

`default_nettype wire

//--- tb/tb_chassis_power.sv
`timescale 1ns/1ps
`default_nettype none

`include "chassis_power_macros.svh"

module tb_chassis_power import chassis_power_pkg::*; ();

  localparam int         FIELDS        = 10;  // Words per trace line
  localparam int         MAX_STEPS     = 64;
  localparam int         RESET_CYCLES  = 5;
  localparam int         MARGIN_CYCLES = 4 * `DEBOUNCE_CYCLES + 50;
  localparam string      TRACE_FILE    = "tb/chassis_power_trace.txt";
  localparam logic [1:0] LED_LIT       = 2'd0;
  localparam logic [1:0] LED_OFF       = 2'd1;
  localparam logic [1:0] LED_BLINK     = 2'd2;

  logic            gclk40;
  logic            hard_reset;
  logic            chs_powerdown_n_i;
  logic            atx_pwr_ok_i;
  logic            ps_on_n_o;
  logic            power_ok_o;
  logic            controller_reset_o;
  no_power_cause_t no_power_cause_o;
  logic [1:0]      chs_led_n_o;

  logic [15:0] trace_mem [0:FIELDS*MAX_STEPS-1];
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;  // Zero until the trace is loaded
  int          error_count = 0;
  int          step_count;
  int          total_cycles;

  chassis_power_top chassis_power_top_inst (
    .gclk40             (gclk40),
    .hard_reset         (hard_reset),
    .chs_powerdown_n_i  (chs_powerdown_n_i),
    .atx_pwr_ok_i       (atx_pwr_ok_i),
    .ps_on_n_o          (ps_on_n_o),
    .power_ok_o         (power_ok_o),
    .controller_reset_o (controller_reset_o),
    .no_power_cause_o   (no_power_cause_o),
    .chs_led_n_o        (chs_led_n_o)
  );

  initial begin
    gclk40 = 1'b0;
    forever #10 gclk40 = ~gclk40;
  end

  always @(posedge gclk40) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the trace did not finish within %0d clock cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic report_error(input string what);
    error_count++;
    $display("error at %0t ns: %s", $time, what);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_led(input int step, input string name, input logic led_n,
                           input logic [1:0] code);
    if (code == LED_LIT) begin
      assert (led_n === 1'b0) else
        report_error($sformatf("step %0d: %s LED is not lit", step, name));
    end else if (code == LED_OFF) begin
      assert (led_n === 1'b1) else
        report_error($sformatf("step %0d: %s LED is not off", step, name));
    end else if (code != LED_BLINK) begin
      report_error($sformatf("step %0d: unknown LED code %0d in trace", step, code));
    end
  endtask

  task automatic check_step(input int step);
    int              base;
    no_power_cause_t exp_cause;
    base      = step * FIELDS;
    exp_cause = no_power_cause_t'(trace_mem[base + 7][1:0]);
    assert (ps_on_n_o === trace_mem[base + 4][0]) else
      report_error($sformatf("step %0d: ps_on_n_o is %b", step, ps_on_n_o));
    assert (power_ok_o === trace_mem[base + 5][0]) else
      report_error($sformatf("step %0d: power_ok_o is %b", step, power_ok_o));
    assert (controller_reset_o === trace_mem[base + 6][0]) else
      report_error($sformatf("step %0d: controller_reset_o is %b", step, controller_reset_o));
    assert (no_power_cause_o === exp_cause) else
      report_error($sformatf("step %0d: cause is %0d, expected %0d", step,
                             no_power_cause_o, exp_cause));
    check_led(step, "power", chs_led_n_o[0], trace_mem[base + 8][1:0]);
    check_led(step, "action", chs_led_n_o[1], trace_mem[base + 9][1:0]);
  endtask

  // A glitch drives the opposite button level for a short random time first
  task automatic run_step(input int step);
    int   base;
    int   hold;
    int   glitch_len;
    logic button_n;
    base         = step * FIELDS;
    hold         = int'(trace_mem[base]);
    button_n     = trace_mem[base + 1][0];
    glitch_len   = 0;
    if (trace_mem[base + 3][0]) begin
      glitch_len = int'($urandom_range(`DEBOUNCE_CYCLES - 2, 1));
    end
    atx_pwr_ok_i      = trace_mem[base + 2][0];
    chs_powerdown_n_i = (glitch_len > 0) ? ~button_n : button_n;
    for (int k = 0; k < hold; k++) begin
      if (k == glitch_len) begin
        chs_powerdown_n_i = button_n;
      end
      @(posedge gclk40);
      #1;
    end
    check_step(step);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    hard_reset        = 1'b0;
    chs_powerdown_n_i = 1'b1;  // Button released
    atx_pwr_ok_i      = 1'b0;
    void'($urandom(9850));
    $readmemh(TRACE_FILE, trace_mem);
    step_count = 0;
    while (step_count < MAX_STEPS && !$isunknown(trace_mem[step_count * FIELDS]) &&
           trace_mem[step_count * FIELDS] != 16'h0000) begin
      step_count++;
    end
    if (step_count == 0) begin
      $display("The trace file %s could not be read or holds no steps", TRACE_FILE);
      $display("SIMULATION FAILED");
      $fatal(1, "No stimulus");
    end
    total_cycles = RESET_CYCLES + MARGIN_CYCLES;
    for (int s = 0; s < step_count; s++) begin
      total_cycles += int'(trace_mem[s * FIELDS]);
    end
    cycle_limit = total_cycles;

    repeat (RESET_CYCLES) @(posedge gclk40);
    #1;
    // Lamp test and safe outputs while reset is still held
    assert (ps_on_n_o === 1'b1 && power_ok_o === 1'b0 && controller_reset_o === 1'b1) else
      report_error("supply outputs wrong during reset");
    assert (no_power_cause_o === CAUSE_NONE) else
      report_error("cause is not CAUSE_NONE during reset");
    assert (chs_led_n_o === 2'b00) else
      report_error($sformatf("LEDs are %b during reset, expected both lit", chs_led_n_o));
    hard_reset = 1'b1;

    for (int s = 0; s < step_count; s++) begin
      run_step(s);
    end

    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/chassis_power_trace.txt
// hold btn_n pg glitch | ps_on_n pwr_ok ctl_rst cause | led_pwr led_act  (all hex)
// LED codes: 0 lit, 1 off, 2 blinking. A hold of 0000 ends the trace

// Out of reset, button released, no power-good
0020 1 0 0  1 0 1 0  2 1

// Held press with power-good present turns the board on
0040 0 1 0  0 1 0 0  0 1
0040 1 1 0  0 1 0 0  0 1

// Short presses while on change nothing
0030 1 1 1  0 1 0 0  0 1
0030 1 1 1  0 1 0 0  0 1
0030 1 1 1  0 1 0 0  0 1

// Press while on starts the power-down wait
0030 0 1 0  0 0 1 0  2 1
0080 1 1 0  1 0 1 3  2 1
// Supply gone, power-good removed
0020 1 0 0  1 0 1 3  2 1

// Short presses while off change nothing
0030 1 0 1  1 0 1 3  2 1
0030 1 0 1  1 0 1 3  2 1

// On again, then power-good drops
0040 0 1 0  0 1 0 3  0 1
0030 1 1 0  0 1 0 3  0 1
0010 1 0 0  1 0 1 1  2 2
0020 1 0 0  1 0 1 1  2 2

// Press without power-good runs into the timeout
0040 0 0 0  0 0 1 1  2 2
0100 1 0 0  1 0 1 2  2 2

0000 0 0 0  0 0 0 0  0 0

//--- flist.f
+incdir+design
design/chassis_power_pkg.sv
design/seq_timer_if.sv
design/switch_debouncer.sv
design/sequence_timer.sv
design/power_sequencer.sv
design/status_leds.sv
design/chassis_power_top.sv
tb/tb_chassis_power.sv

//--- run_sim.sh
#!/bin/sh
# Compile the chassis power testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

TOP=tb_chassis_power
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module "$TOP" --Mdir "$BUILD_DIR" -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
  echo "Result: pass"
  exit 0
fi
echo "Result: fail"
exit 1
